//--- Makefile
VERILATOR ?= verilator
TOP ?= cacheSubsystem_tb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= TEST RESULT: PASS
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
design/cachePkg.sv
design/lineMemory.sv
design/dataCache.sv
design/cacheSubsystem.sv
sim/cacheSubsystem_properties.sv
sim/cacheSubsystem_tb.sv

//--- design/cachePkg.sv
package cachePkg;

    // processor word and address
    localparam int wordWidth = 32;
    localparam int addrWidth = 16;
    localparam int byteWidth = 8;

    // line geometry
    localparam int lineWords = 4;
    localparam int lineWidth = wordWidth * lineWords;

    // address split, high to low: tag, index, word select, byte select
    localparam int indexBits = 4;
    localparam int wordSelBits = 2;
    localparam int byteSelBits = 2;
    localparam int tagBits = addrWidth - indexBits - wordSelBits - byteSelBits;

    localparam int numLines = 1 << indexBits;
    localparam int lineAddrBits = tagBits + indexBits;

    typedef logic [wordWidth-1:0] wordT;
    // word 0 sits in the low bits
    typedef logic [lineWidth-1:0] lineT;
    typedef logic [lineAddrBits-1:0] lineAddrT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [indexBits-1:0] indexT;

    typedef struct packed {
        tagT tag;
        indexT index;
        logic [wordSelBits-1:0] wordSel;
        logic [byteSelBits-1:0] byteSel;
    } cacheAddrFieldsT;

    // same byte address, seen raw or split into fields
    typedef union packed {
        logic [addrWidth-1:0] raw;
        cacheAddrFieldsT fields;
    } cacheAddrU;

    typedef struct packed {
        logic write;
        // ignored on stores
        logic byteLoad;
        cacheAddrU addr;
        wordT wdata;
    } cpuReqT;

    typedef struct packed {
        logic write;
        lineAddrT lineAddr;
        lineT wline;
    } memReqT;

endpackage

//--- design/cacheSubsystem.sv
`timescale 1ns/1ps

module cacheSubsystem #(
    parameter int memLatency = 3
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              cpuReqValid,
    input  cachePkg::cpuReqT  cpuReq,
    output logic              cpuAck,
    output cachePkg::wordT    cpuRdata
);

    import cachePkg::*;

    // cache to memory link
    logic memReqValid;
    memReqT memReq;
    logic memAck;
    lineT memRline;

    dataCache i_dataCache (
        .clk         (clk),
        .rstN        (rstN),
        .cpuReqValid (cpuReqValid),
        .cpuReq      (cpuReq),
        .cpuAck      (cpuAck),
        .cpuRdata    (cpuRdata),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memAck      (memAck),
        .memRline    (memRline)
    );

    lineMemory #(
        .memLatency (memLatency)
    ) i_lineMemory (
        .clk         (clk),
        .rstN        (rstN),
        .memReqValid (memReqValid),
        .memReq      (memReq),
        .memAck      (memAck),
        .memRline    (memRline)
    );

endmodule

//--- design/dataCache.sv
`timescale 1ns/1ps

module dataCache (
    input  logic              clk,
    input  logic              rstN,
    input  logic              cpuReqValid,
    input  cachePkg::cpuReqT  cpuReq,
    output logic              cpuAck,
    output cachePkg::wordT    cpuRdata,
    output logic              memReqValid,
    output cachePkg::memReqT  memReq,
    input  logic              memAck,
    input  cachePkg::lineT    memRline
);

    import cachePkg::*;

    typedef enum logic [2:0] {
        idleS,
        lookupS,
        writeBackS,
        fillS,
        ackS
    } stateT;

    stateT state;

    // line storage, one way
    lineT dataMem [numLines];
    tagT tagMem [numLines];
    logic [numLines-1:0] validBits;
    logic [numLines-1:0] dirtyBits;

    cacheAddrFieldsT reqFields;
    indexT idx;
    logic hit;
    logic victimDirty;
    logic hitNow;
    logic missNow;
    logic memDone;
    logic memIdle;
    logic fillDone;
    logic startFill;
    wordT hitWord;
    logic [byteWidth-1:0] hitByte;
    wordT loadData;

    // requester keeps cpuReq stable until the ack, so no local copy
    assign reqFields = cpuReq.addr.fields;
    assign idx = reqFields.index;

    assign hit = validBits[idx] && (tagMem[idx] == reqFields.tag);
    assign victimDirty = validBits[idx] && dirtyBits[idx];

    assign hitNow = (state == lookupS) && hit;
    assign missNow = (state == lookupS) && !hit;

    // memory handshake phases
    assign memDone = memReqValid && memAck;
    assign memIdle = !memReqValid && !memAck;

    assign fillDone = (state == fillS) && memDone;
    // fill goes out straight from a clean miss, or once the write-back handshake closes
    assign startFill = (missNow && !victimDirty) || ((state == writeBackS) && memIdle);

    // load data selection
    assign hitWord = dataMem[idx][reqFields.wordSel * wordWidth +: wordWidth];
    assign hitByte = hitWord[reqFields.byteSel * byteWidth +: byteWidth];
    assign loadData = cpuReq.byteLoad ? {{(wordWidth - byteWidth){1'b0}}, hitByte} : hitWord;

    // data, tags and the payload registers
    always_ff @(posedge clk) begin
        if (hitNow && cpuReq.write) begin
            dataMem[idx][reqFields.wordSel * wordWidth +: wordWidth] <= cpuReq.wdata;
        end
        if (fillDone) begin
            dataMem[idx] <= memRline;
            tagMem[idx] <= reqFields.tag;
        end
        if (hitNow) begin
            cpuRdata <= loadData;
        end
        if (missNow && victimDirty) begin
            // victim goes back at its own tag
            memReq.write <= 1'b1;
            memReq.lineAddr <= {tagMem[idx], idx};
            memReq.wline <= dataMem[idx];
        end else if (startFill) begin
            memReq.write <= 1'b0;
            memReq.lineAddr <= cpuReq.addr.raw[addrWidth-1 -: lineAddrBits];
        end
    end

    // control FSM, valid and dirty bits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idleS;
            cpuAck <= 1'b0;
            memReqValid <= 1'b0;
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            case (state)
                idleS: begin
                    if (cpuReqValid) begin
                        state <= lookupS;
                    end
                end
                lookupS: begin
                    if (hit) begin
                        if (cpuReq.write) begin
                            dirtyBits[idx] <= 1'b1;
                        end
                        state <= ackS;
                    end else begin
                        memReqValid <= 1'b1;
                        state <= victimDirty ? writeBackS : fillS;
                    end
                end
                writeBackS: begin
                    if (memDone) begin
                        memReqValid <= 1'b0;
                    end else if (memIdle) begin
                        memReqValid <= 1'b1;
                        state <= fillS;
                    end
                end
                fillS: begin
                    if (memDone) begin
                        memReqValid <= 1'b0;
                        validBits[idx] <= 1'b1;
                        dirtyBits[idx] <= 1'b0;
                    end else if (memIdle) begin
                        // replay, now a hit
                        state <= lookupS;
                    end
                end
                ackS: begin
                    // first cycle raises the ack, then wait for the request to drop
                    if (!cpuAck) begin
                        cpuAck <= 1'b1;
                    end else if (!cpuReqValid) begin
                        cpuAck <= 1'b0;
                        state <= idleS;
                    end
                end
                default: begin
                    state <= idleS;
                end
            endcase
        end
    end

endmodule

//--- design/lineMemory.sv
`timescale 1ns/1ps

module lineMemory #(
    parameter int memLatency = 3
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              memReqValid,
    input  cachePkg::memReqT  memReq,
    output logic              memAck,
    output cachePkg::lineT    memRline
);

    import cachePkg::*;

    localparam int numLineAddrs = 1 << lineAddrBits;
    localparam int cntWidth = (memLatency > 1) ? $clog2(memLatency) : 1;

    // one entry per line address
    lineT mem [numLineAddrs];

    logic busy;
    logic [cntWidth-1:0] latencyCnt;
    logic respond;

    // counter has run out on an open request
    assign respond = busy && (latencyCnt == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            latencyCnt <= '0;
            memAck <= 1'b0;
        end else if (memAck) begin
            // hold ack until the request drops
            if (!memReqValid) begin
                memAck <= 1'b0;
            end
        end else if (respond) begin
            busy <= 1'b0;
            memAck <= 1'b1;
        end else if (busy) begin
            latencyCnt <= latencyCnt - 1'b1;
        end else if (memReqValid) begin
            busy <= 1'b1;
            latencyCnt <= cntWidth'(memLatency - 1);
        end
    end

    // array access happens as the ack goes up
    always_ff @(posedge clk) begin
        if (respond) begin
            if (memReq.write) begin
                mem[memReq.lineAddr] <= memReq.wline;
            end else begin
                memRline <= mem[memReq.lineAddr];
            end
        end
    end

endmodule

//--- sim/cacheSubsystem_properties.sv
`timescale 1ns/1ps

module cacheSubsystem_properties (
    input logic              clk,
    input logic              rstN,
    input logic              cpuReqValid,
    input logic              cpuAck,
    input logic              memReqValid,
    input cachePkg::memReqT  memReq,
    input logic              memAck
);

    int violations = 0;

    // ack only answers a request that was up on the edge that raised it
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(cpuAck) |-> $past(cpuReqValid))
        else begin
            $error("cpuAck rose while cpuReqValid was low");
            violations++;
        end

    // memory request held until the line memory acks
    memReqStable: assert property (@(posedge clk) disable iff (!rstN)
        (memReqValid && !memAck) |=> $stable(memReq))
        else begin
            $error("memReq changed before memAck");
            violations++;
        end

    ackFallsAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $fell(cpuAck) |-> !$past(cpuReqValid))
        else begin
            $error("cpuAck fell while cpuReqValid was still high");
            violations++;
        end

endmodule

bind dataCache cacheSubsystem_properties i_handshakeProps (
    .clk         (clk),
    .rstN        (rstN),
    .cpuReqValid (cpuReqValid),
    .cpuAck      (cpuAck),
    .memReqValid (memReqValid),
    .memReq      (memReq),
    .memAck      (memAck)
);

//--- sim/cacheSubsystem_tb.sv
`timescale 1ns/1ps

module cacheSubsystem_tb;

    import cachePkg::*;

    localparam int memLatency = 3;
    localparam int resetCycles = 16;
    // processor transactions over all tests
    localparam int numOps = 64 + 5 + 12 + 400 + 3;
    localparam int cycleLimit = numOps * (2 * memLatency + 8) + resetCycles;

    logic clk;
    logic rstN;
    logic cpuReqValid;
    cpuReqT cpuReq;
    logic cpuAck;
    wordT cpuRdata;

    logic [31:0] lfsrState;
    int cycleCount;
    int passCount;
    int failCount;
    int testFails;
    // reference memory, written words keyed by word address
    wordT model [int];
    // only four tags, so lines collide often
    tagT tagPool [4];

    cacheSubsystem #(
        .memLatency (memLatency)
    ) i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .cpuReqValid (cpuReqValid),
        .cpuReq      (cpuReq),
        .cpuAck      (cpuAck),
        .cpuRdata    (cpuRdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no result after %0d clock cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input wordT expected, input wordT actual);
        assert (actual === expected) begin
            passCount++;
        end else begin
            $display("Error: time %0t, %s expected %h actual %h", $time, name, expected, actual);
            failCount++;
            testFails++;
        end
    endtask

    // one four-phase transaction, called on a falling edge
    task automatic access(input logic write, input logic byteLoad, input logic [15:0] addr,
                          input wordT wdata, output wordT rdata, output int latency);
        int edges;
        edges = 0;
        cpuReq.write = write;
        cpuReq.byteLoad = byteLoad;
        cpuReq.addr.raw = addr;
        cpuReq.wdata = wdata;
        cpuReqValid = 1'b1;
        do begin
            @(negedge clk);
            edges++;
        end while (!cpuAck);
        // rising edges after the one that sampled the request
        latency = edges - 1;
        rdata = cpuRdata;
        cpuReqValid = 1'b0;
        do begin
            @(negedge clk);
        end while (cpuAck);
    endtask

    task automatic storeWord(input logic [15:0] addr, input wordT data);
        wordT ignored;
        int lat;
        access(1'b1, 1'b0, addr, data, ignored, lat);
        model[int'(addr[15:2])] = data;
    endtask

    task automatic loadCheck(input logic byteLoad, input logic [15:0] addr, output int latency);
        wordT word;
        wordT expected;
        wordT got;
        word = model[int'(addr[15:2])];
        expected = byteLoad ? {24'h0, word[8 * addr[1:0] +: 8]} : word;
        access(1'b0, byteLoad, addr, '0, got, latency);
        if (byteLoad) begin
            checkValue("cpuRdata (byte load)", expected, got);
        end else begin
            checkValue("cpuRdata", expected, got);
        end
    endtask

    task automatic endTest(input string name);
        $display("test %s done, %0d errors", name, testFails);
        testFails = 0;
    endtask

    initial begin
        logic [15:0] addr;
        logic [1:0] slot;
        logic [1:0] wordSel;
        logic [1:0] byteSel;
        logic [1:0] opSel;
        indexT idx;
        lineAddrT lastLine;
        int lat;
        lfsrState = 32'hd87abb6b;
        cycleCount = 0;
        passCount = 0;
        failCount = 0;
        testFails = 0;
        tagPool[0] = 8'h00;
        tagPool[1] = 8'h3c;
        tagPool[2] = 8'ha5;
        tagPool[3] = 8'hf1;
        rstN = 1'b0;
        cpuReqValid = 1'b0;
        cpuReq = '0;

        // ack stays low in reset and while no request is up
        repeat (resetCycles) begin
            @(negedge clk);
            checkValue("cpuAck", '0, wordT'(cpuAck));
        end
        rstN = 1'b1;
        repeat (4) begin
            @(negedge clk);
            checkValue("cpuAck", '0, wordT'(cpuAck));
        end
        endTest("reset");

        // first half on tag slots 0 and 1, second half on 2 and 3, one line each
        for (int k = 0; k < 32; k++) begin
            slot = 2'(2 * (k / 16)) | 2'(randBits(1));
            wordSel = 2'(randBits(2));
            addr = {tagPool[slot], indexT'(k), wordSel, 2'b00};
            storeWord(addr, randBits(32));
            loadCheck(1'b0, addr, lat);
        end
        endTest("store then load");

        slot = 2'(randBits(2));
        idx = indexT'(randBits(4));
        wordSel = 2'(randBits(2));
        addr = {tagPool[slot], idx, wordSel, 2'b00};
        storeWord(addr, randBits(32));
        for (int b = 0; b < 4; b++) begin
            loadCheck(1'b1, {addr[15:2], 2'(b)}, lat);
        end
        endTest("byte load");

        // B evicts a dirty A, then loading A evicts a dirty B
        repeat (4) begin
            slot = 2'(randBits(2));
            idx = indexT'(randBits(4));
            wordSel = 2'(randBits(2));
            addr = {tagPool[slot], idx, wordSel, 2'b00};
            storeWord(addr, randBits(32));
            slot = slot + 2'd1;
            storeWord({tagPool[slot], idx, wordSel, 2'b00}, randBits(32));
            loadCheck(1'b0, addr, lat);
        end
        endTest("conflict eviction");

        lastLine = {tagPool[0], 4'h0};
        for (int n = 0; n < 400; n++) begin
            // three ops in four stay on the previous line
            if (randBits(2) == 0) begin
                slot = 2'(randBits(2));
                idx = indexT'(randBits(4));
                lastLine = {tagPool[slot], idx};
            end
            wordSel = 2'(randBits(2));
            byteSel = 2'(randBits(2));
            opSel = 2'(randBits(2));
            addr = {lastLine, wordSel, byteSel};
            if (opSel[1] == 1'b0 || !model.exists(int'(addr[15:2]))) begin
                storeWord({addr[15:2], 2'b00}, randBits(32));
            end else begin
                loadCheck(opSel[0], addr, lat);
            end
        end
        endTest("random mix");

        slot = 2'(randBits(2));
        idx = indexT'(randBits(4));
        wordSel = 2'(randBits(2));
        addr = {tagPool[slot], idx, wordSel, 2'b00};
        storeWord(addr, randBits(32));
        loadCheck(1'b0, addr, lat);
        checkValue("hit latency", 32'd2, wordT'(lat));
        loadCheck(1'b1, {addr[15:2], 2'b10}, lat);
        checkValue("hit latency", 32'd2, wordT'(lat));
        checkValue("handshake assertion failures", '0,
                   wordT'(i_dut.i_dataCache.i_handshakeProps.violations));
        endTest("hit latency");

        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
